// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_l2_cache \
		-Mdir obj_dir -o tb_l2_cache -f filelist.f
	./obj_dir/tb_l2_cache | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/naxi_mem_slave.sv ====
module naxi_mem_slave #(
    parameter int ADDR_W = cache_pkg::ADDR_W_DEF,
    parameter int DATA_W = cache_pkg::DATA_W_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           rnd,  // Stall in bits 1:0, read latency in bits 4:2
    input  logic                 m_creq_valid,
    input  cache_pkg::req_type_e m_creq_type,
    input  logic [ADDR_W-1:0]    m_creq_addr,
    input  logic [DATA_W-1:0]    m_creq_data,
    output logic                 m_creq_stall,
    output logic                 m_rreq_valid,
    output logic [DATA_W-1:0]    m_rreq_data
);

    import cache_pkg::*;

    localparam int OFF_W = $clog2(DATA_W / 8);
    localparam int WORDS = 2 ** (ADDR_W - OFF_W);

    logic [DATA_W-1:0] mem [WORDS];
    logic [ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic              acc;
    req_type_e         acc_type;
    logic [ADDR_W-1:0] acc_addr;
    logic [DATA_W-1:0] acc_data;
    logic [4:0]        rnd_q;
    logic [ADDR_W-1:0] rd_addr;
    int                rd_wait;
    int                err_cnt;
    int                wr_left;

    // Called by the testbench as it issues each write
    task automatic expect_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        wr_left++;
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got, exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    // Command port is stable mid-cycle
    always @(negedge clk) begin
        acc      = rst_n && m_creq_valid && !m_creq_stall;
        acc_type = m_creq_type;
        acc_addr = m_creq_addr;
        acc_data = m_creq_data;
        rnd_q    = rnd;
    end

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
        acc = 1'b0;
        rnd_q = '0;
        rd_wait = 0;
        err_cnt = 0;
        wr_left = 0;
        m_creq_stall = 1'b0;
        m_rreq_valid = 1'b0;
        m_rreq_data = '0;
        forever begin
            @(posedge clk);
            #1;
            m_rreq_valid = 1'b0;  // Single-cycle return pulse
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    m_rreq_valid = 1'b1;
                    m_rreq_data = mem[rd_addr[ADDR_W-1:OFF_W]];
                end
            end
            if (acc && acc_type == REQ_WRITE) begin
                if (exp_addr.size() == 0) begin
                    $display("Unexpected downstream write to 0x%h at %0t", acc_addr, $time);
                    err_cnt++;
                end else begin
                    check_addr("m_creq_addr", acc_addr, exp_addr.pop_front());
                    check_data("m_creq_data", acc_data, exp_data.pop_front());
                    wr_left--;
                end
                mem[acc_addr[ADDR_W-1:OFF_W]] = acc_data;
            end else if (acc) begin
                rd_wait = int'(rnd_q[4:2]) + 1;  // 1 to 8 cycles
                rd_addr = acc_addr;
            end
            m_creq_stall = (rnd_q[1:0] == 2'b00);
        end
    end

endmodule

// ==== bench/tb_l2_cache.sv ====
module tb_l2_cache;

    import cache_pkg::*;

    localparam int ADDR_W    = ADDR_W_DEF;
    localparam int DATA_W    = DATA_W_DEF;
    localparam int NUM_ROWS  = NUM_ROWS_DEF;
    localparam int MEM_DELAY = MEM_DELAY_DEF;
    localparam int ID_W      = ID_W_DEF;
    localparam int IDX_W     = $clog2(NUM_ROWS);
    localparam int OFF_W     = $clog2(DATA_W / 8);
    localparam int TAG_W     = ADDR_W - IDX_W - OFF_W;
    localparam int NUM_REQ   = 2000;
    localparam int TIMEOUT   = NUM_REQ * 40 + 200;

    typedef struct packed {
        req_type_e         typ;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;  // Expected response data
        logic              hit;
    } resp_exp_t;

    logic              clk;
    logic              rst_n;
    logic              s_creq_valid;
    req_type_e         s_creq_type;
    logic [ID_W-1:0]   s_creq_id;
    logic [ADDR_W-1:0] s_creq_addr;
    logic [DATA_W-1:0] s_dreq_data;
    logic              s_creq_stall;
    logic              s_rreq_valid;
    logic [ID_W-1:0]   s_rreq_id;
    logic [DATA_W-1:0] s_rreq_data;
    logic              s_rreq_stall;
    logic              m_creq_valid;
    req_type_e         m_creq_type;
    logic [ADDR_W-1:0] m_creq_addr;
    logic [DATA_W-1:0] m_creq_data;
    logic              m_creq_stall;
    logic              m_rreq_valid;
    logic [DATA_W-1:0] m_rreq_data;
    logic              e_cch_rhit;
    logic              e_cch_whit;
    logic [4:0]        slave_rnd;

    logic [31:0] stim_lfsr;
    logic [31:0] noise_lfsr;
    int          cycle_cnt;
    int          n_checks;
    int          n_errors;
    int          n_resp;

    // Reference model
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    logic              ref_valid [NUM_ROWS][2];
    logic [TAG_W-1:0]  ref_tag [NUM_ROWS][2];
    logic              ref_lru [NUM_ROWS];
    resp_exp_t         exp_q [$];

    // Observations for the request in flight
    int                acc_cyc;
    int                rhit_seen;
    int                whit_seen;
    int                ds_rd_seen;
    int                ds_wr_seen;
    logic              held;
    logic [ID_W-1:0]   held_id;
    logic [DATA_W-1:0] held_data;

    l2_cache_top #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .NUM_ROWS  (NUM_ROWS),
        .MEM_DELAY (MEM_DELAY),
        .ID_W      (ID_W)
    ) DUT (.*);

    naxi_mem_slave #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_slave (.*, .rnd(slave_rnd));

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], s[0]};
            s = lfsr_step(s);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input logic [ID_W-1:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_type(input string name, input req_type_e got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s = %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Predicts hit and response data, then updates tags, LRU and memory
    task automatic model_access(inout resp_exp_t e, input logic [DATA_W-1:0] wdata);
        int               idx;
        int               way;
        logic [TAG_W-1:0] tag;
        idx = int'(e.addr[OFF_W +: IDX_W]);
        tag = e.addr[ADDR_W-1 -: TAG_W];
        e.hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                e.hit = 1'b1;
                way = w;
            end
        end
        if (!e.hit && e.typ == REQ_READ) begin
            // Invalid way first, else the LRU way
            way = !ref_valid[idx][0] ? 0 : (!ref_valid[idx][1] ? 1 : int'(ref_lru[idx]));
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way] = tag;
        end
        if (e.hit || e.typ == REQ_READ) begin
            ref_lru[idx] = (way == 0);  // Other way is next victim
        end
        if (e.typ == REQ_WRITE) begin
            ref_mem[e.addr] = wdata;
            e.data = '0;
        end else begin
            e.data = ref_mem.exists(e.addr) ? ref_mem[e.addr] : '0;
        end
    endtask

    task automatic check_response();
        resp_exp_t e;
        if (exp_q.size() == 0) begin
            $display("Response at %0t with no request outstanding", $time);
            n_errors++;
            return;
        end
        e = exp_q[0];
        if (!held) begin
            check_id("s_rreq_id", s_rreq_id, e.id);
            check_data("s_rreq_data", s_rreq_data, e.data);
            if (e.typ == REQ_READ && e.hit) begin
                check_count("read hit latency", cycle_cnt - acc_cyc, MEM_DELAY + 2);
            end
            held_id = s_rreq_id;
            held_data = s_rreq_data;
        end else begin
            check_id("s_rreq_id under stall", s_rreq_id, held_id);
            check_data("s_rreq_data under stall", s_rreq_data, held_data);
        end
        held = s_rreq_stall;
        if (!s_rreq_stall) begin
            check_count("e_cch_rhit pulses", rhit_seen, (e.typ == REQ_READ && e.hit) ? 1 : 0);
            check_count("e_cch_whit pulses", whit_seen, (e.typ == REQ_WRITE && e.hit) ? 1 : 0);
            check_count("downstream reads", ds_rd_seen, (e.typ == REQ_READ && !e.hit) ? 1 : 0);
            check_count("downstream writes", ds_wr_seen, (e.typ == REQ_WRITE) ? 1 : 0);
            void'(exp_q.pop_front());
            n_resp++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Response stall and slave randomness
    initial begin : noise
        logic [31:0] r;
        noise_lfsr = 32'h84e8_1cbc;
        s_rreq_stall = 1'b0;
        slave_rnd = '0;
        forever begin
            @(posedge clk);
            #1;
            take_bits(noise_lfsr, 7, r);
            s_rreq_stall = (r[1:0] == 2'b11);
            slave_rnd = r[6:2];
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (s_creq_valid && !s_creq_stall) begin
                acc_cyc = cycle_cnt;
                rhit_seen = 0;
                whit_seen = 0;
                ds_rd_seen = 0;
                ds_wr_seen = 0;
            end
            rhit_seen += int'(e_cch_rhit);
            whit_seen += int'(e_cch_whit);
            if (m_creq_valid && !m_creq_stall && exp_q.size() == 0) begin
                $display("Downstream command at %0t with no request outstanding", $time);
                n_errors++;
            end else if (m_creq_valid && !m_creq_stall) begin
                check_type("m_creq_type", m_creq_type, exp_q[0].typ);
                check_addr("m_creq_addr", m_creq_addr, exp_q[0].addr);
                if (m_creq_type == REQ_READ) begin
                    ds_rd_seen++;
                end else begin
                    ds_wr_seen++;
                end
            end
            if (s_rreq_valid) begin
                check_response();
            end else if (held) begin
                $display("s_rreq_valid dropped at %0t before the response was taken", $time);
                n_errors++;
                held = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles with %0d of %0d responses", cycle_cnt, n_resp, NUM_REQ);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        resp_exp_t         e;
        logic [31:0]       r;
        logic [DATA_W-1:0] wdata;
        logic              taken;
        rst_n = 1'b0;
        s_creq_valid = 1'b0;
        s_creq_type = REQ_READ;
        s_creq_id = '0;
        s_creq_addr = '0;
        s_dreq_data = '0;
        stim_lfsr = 32'h84e8_1cbc;
        n_checks = 0;
        n_errors = 0;
        n_resp = 0;
        held = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            ref_valid[i][0] = 1'b0;
            ref_valid[i][1] = 1'b0;
            ref_lru[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_REQ; n++) begin
            take_bits(stim_lfsr, 5, r);
            e.typ = (r < 13) ? REQ_WRITE : REQ_READ;  // About 40% writes
            take_bits(stim_lfsr, IDX_W + 2, r);
            e.addr = ADDR_W'(r) << OFF_W;  // 4 tags over all sets
            take_bits(stim_lfsr, ID_W, r);
            e.id = r[ID_W-1:0];
            take_bits(stim_lfsr, DATA_W, r);
            wdata = r[DATA_W-1:0];
            model_access(e, wdata);
            exp_q.push_back(e);
            if (e.typ == REQ_WRITE) begin
                mem_slave.expect_write(e.addr, wdata);
            end
            s_creq_valid = 1'b1;
            s_creq_type = e.typ;
            s_creq_id = e.id;
            s_creq_addr = e.addr;
            s_dreq_data = wdata;
            do begin
                @(negedge clk);
                taken = !s_creq_stall;
                @(posedge clk);
                #1;
            end while (!taken);
            s_creq_valid = 1'b0;
            take_bits(stim_lfsr, 1, r);
            if (r[0]) begin
                @(posedge clk);  // Idle gap
                #1;
            end
        end
        while (n_resp < NUM_REQ) @(posedge clk);
        repeat (10) @(posedge clk);
        if (mem_slave.wr_left != 0) begin
            $display("%0d writes never reached the downstream port", mem_slave.wr_left);
            n_errors++;
        end
        $display("Requests %0d, responses %0d, checks %0d, errors %0d, downstream errors %0d",
                 NUM_REQ, n_resp, n_checks, n_errors, mem_slave.err_cnt);
        if (n_errors == 0 && mem_slave.err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/cache_pkg.sv
verilog/mem_beh_1r1w.sv
verilog/l2_cache_ctrl.sv
verilog/l2_cache_top.sv
bench/naxi_mem_slave.sv
bench/tb_l2_cache.sv

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // Command type on both the upstream and downstream ports
    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_type_e;

    // Controller FSM
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,  // Waiting for an upstream command
        ST_LOOKUP  = 3'd1,  // Tag and data reads in flight
        ST_COMPARE = 3'd2,  // Tag compare, hit/miss decision
        ST_DS_REQ  = 3'd3,  // Downstream command presented
        ST_DS_WAIT = 3'd4,  // Waiting for downstream read return
        ST_FILL    = 3'd5,  // Line refill into the victim way
        ST_RESP    = 3'd6   // Upstream response held until taken
    } ctrl_state_e;

    // Byte address width
    localparam int ADDR_W_DEF = 16;

    // One word per line
    localparam int DATA_W_DEF = 32;

    // Sets per way
    localparam int NUM_ROWS_DEF = 64;

    // Tag and data memory read latency in cycles
    localparam int MEM_DELAY_DEF = 3;

    // Upstream transaction id width
    localparam int ID_W_DEF = 5;

endpackage

// ==== verilog/l2_cache_ctrl.sv ====
module l2_cache_ctrl #(
    parameter int  ADDR_W    = cache_pkg::ADDR_W_DEF,
    parameter int  DATA_W    = cache_pkg::DATA_W_DEF,
    parameter int  NUM_ROWS  = cache_pkg::NUM_ROWS_DEF,
    parameter int  MEM_DELAY = cache_pkg::MEM_DELAY_DEF,
    parameter int  ID_W      = cache_pkg::ID_W_DEF,
    localparam int IDX_W     = $clog2(NUM_ROWS),
    localparam int OFF_W     = $clog2(DATA_W / 8),
    localparam int TAG_W     = ADDR_W - IDX_W - OFF_W,
    localparam int TROW_W    = 2 * (TAG_W + 1) + 1,
    localparam int DROW_W    = 2 * DATA_W
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   s_creq_valid,
    input  cache_pkg::req_type_e   s_creq_type,
    input  logic [ID_W-1:0]        s_creq_id,
    input  logic [ADDR_W-1:0]      s_creq_addr,
    input  logic [DATA_W-1:0]      s_dreq_data,
    output logic                   s_creq_stall,

    output logic                   s_rreq_valid,
    output logic [ID_W-1:0]        s_rreq_id,
    output logic [DATA_W-1:0]      s_rreq_data,
    input  logic                   s_rreq_stall,

    output logic                   m_creq_valid,
    output cache_pkg::req_type_e   m_creq_type,
    output logic [ADDR_W-1:0]      m_creq_addr,
    output logic [DATA_W-1:0]      m_creq_data,
    input  logic                   m_creq_stall,

    input  logic                   m_rreq_valid,
    input  logic [DATA_W-1:0]      m_rreq_data,

    output logic                   e_cch_rhit,
    output logic                   e_cch_whit,

    output logic                   tag_we,
    output logic [IDX_W-1:0]       tag_waddr,
    output logic [TROW_W-1:0]      tag_wdata,
    output logic                   tag_re,
    output logic [IDX_W-1:0]       tag_raddr,
    input  logic [TROW_W-1:0]      tag_rdata,

    output logic                   dat_we,
    output logic [IDX_W-1:0]       dat_waddr,
    output logic [DROW_W-1:0]      dat_wdata,
    output logic                   dat_re,
    output logic [IDX_W-1:0]       dat_raddr,
    input  logic [DROW_W-1:0]      dat_rdata
);

    import cache_pkg::*;

    localparam int CNT_W = $clog2(MEM_DELAY + 1);
    localparam int WAY_W = TAG_W + 1;  // Valid bit plus tag

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic [CNT_W-1:0] cnt;

    req_type_e type_q;
    logic [ID_W-1:0] id_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic [TROW_W-1:0] tag_row_q;
    logic [DROW_W-1:0] dat_row_q;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic hit0;
    logic hit1;
    logic hit;
    logic hit_way;
    logic [DATA_W-1:0] hit_word;
    logic victim;
    logic [TROW_W-1:0] hit_tag_row;
    logic [DROW_W-1:0] hit_dat_row;
    logic [TROW_W-1:0] fill_tag_row;
    logic [DROW_W-1:0] fill_dat_row;

    assign req_idx = addr_q[OFF_W +: IDX_W];
    assign req_tag = addr_q[ADDR_W-1 -: TAG_W];

    // Row layout is {lru, v1, tag1, v0, tag0}
    assign hit0 = tag_rdata[WAY_W-1] && (tag_rdata[TAG_W-1:0] == req_tag);
    assign hit1 = tag_rdata[2*WAY_W-1] && (tag_rdata[WAY_W +: TAG_W] == req_tag);
    assign hit = hit0 || hit1;
    assign hit_way = hit1;
    assign hit_word = hit_way ? dat_rdata[DATA_W +: DATA_W] : dat_rdata[DATA_W-1:0];

    // Invalid way first, then the one named by LRU
    assign victim = !tag_row_q[WAY_W-1]   ? 1'b0 :
                    !tag_row_q[2*WAY_W-1] ? 1'b1 : tag_row_q[TROW_W-1];

    always_comb begin
        hit_tag_row = tag_rdata;
        hit_tag_row[TROW_W-1] = ~hit_way;  // Other way becomes LRU
        hit_dat_row = dat_rdata;
        hit_dat_row[int'(hit_way)*DATA_W +: DATA_W] = wdata_q;
    end

    always_comb begin
        fill_tag_row = tag_row_q;
        fill_tag_row[int'(victim)*WAY_W +: WAY_W] = {1'b1, req_tag};
        fill_tag_row[TROW_W-1] = ~victim;
        fill_dat_row = dat_row_q;
        fill_dat_row[int'(victim)*DATA_W +: DATA_W] = rdata_q;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (s_creq_valid) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (cnt == CNT_W'(MEM_DELAY - 1)) begin
                    state_nxt = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (hit && type_q == REQ_READ) begin
                    state_nxt = ST_RESP;
                end else begin
                    state_nxt = ST_DS_REQ;  // Write-through or read miss
                end
            end
            ST_DS_REQ: begin
                if (!m_creq_stall) begin
                    state_nxt = (type_q == REQ_WRITE) ? ST_RESP : ST_DS_WAIT;
                end
            end
            ST_DS_WAIT: begin
                if (m_rreq_valid) begin
                    state_nxt = ST_FILL;
                end
            end
            ST_FILL: state_nxt = ST_RESP;
            ST_RESP: begin
                if (!s_rreq_stall) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= (state == ST_LOOKUP) ? cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && s_creq_valid) begin
            type_q  <= s_creq_type;
            id_q    <= s_creq_id;
            addr_q  <= {s_creq_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};  // Word aligned
            wdata_q <= s_dreq_data;
        end
        if (state == ST_COMPARE) begin
            tag_row_q <= tag_rdata;
            dat_row_q <= dat_rdata;
            rdata_q   <= (type_q == REQ_READ) ? hit_word : '0;
        end
        if (state == ST_DS_WAIT && m_rreq_valid) begin
            rdata_q <= m_rreq_data;  // Response data and fill word
        end
    end

    assign s_creq_stall = (state != ST_IDLE);

    assign s_rreq_valid = (state == ST_RESP);
    assign s_rreq_id    = id_q;
    assign s_rreq_data  = rdata_q;

    assign m_creq_valid = (state == ST_DS_REQ);
    assign m_creq_type  = type_q;
    assign m_creq_addr  = addr_q;
    assign m_creq_data  = wdata_q;

    assign e_cch_rhit = (state == ST_COMPARE) && hit && (type_q == REQ_READ);
    assign e_cch_whit = (state == ST_COMPARE) && hit && (type_q == REQ_WRITE);

    // Both reads issued once, in the first lookup cycle
    assign tag_re    = (state == ST_LOOKUP) && (cnt == '0);
    assign tag_raddr = req_idx;
    assign dat_re    = tag_re;
    assign dat_raddr = req_idx;

    // Hits refresh LRU, write hits also update the word
    assign tag_we    = ((state == ST_COMPARE) && hit) || (state == ST_FILL);
    assign tag_waddr = req_idx;
    assign tag_wdata = (state == ST_FILL) ? fill_tag_row : hit_tag_row;
    assign dat_we    = (e_cch_whit) || (state == ST_FILL);
    assign dat_waddr = req_idx;
    assign dat_wdata = (state == ST_FILL) ? fill_dat_row : hit_dat_row;

endmodule

// ==== verilog/l2_cache_top.sv ====
module l2_cache_top #(
    parameter int ADDR_W    = cache_pkg::ADDR_W_DEF,
    parameter int DATA_W    = cache_pkg::DATA_W_DEF,
    parameter int NUM_ROWS  = cache_pkg::NUM_ROWS_DEF,
    parameter int MEM_DELAY = cache_pkg::MEM_DELAY_DEF,
    parameter int ID_W      = cache_pkg::ID_W_DEF
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   s_creq_valid,
    input  cache_pkg::req_type_e   s_creq_type,
    input  logic [ID_W-1:0]        s_creq_id,
    input  logic [ADDR_W-1:0]      s_creq_addr,
    input  logic [DATA_W-1:0]      s_dreq_data,
    output logic                   s_creq_stall,

    output logic                   s_rreq_valid,
    output logic [ID_W-1:0]        s_rreq_id,
    output logic [DATA_W-1:0]      s_rreq_data,
    input  logic                   s_rreq_stall,

    output logic                   m_creq_valid,
    output cache_pkg::req_type_e   m_creq_type,
    output logic [ADDR_W-1:0]      m_creq_addr,
    output logic [DATA_W-1:0]      m_creq_data,
    input  logic                   m_creq_stall,

    input  logic                   m_rreq_valid,
    input  logic [DATA_W-1:0]      m_rreq_data,

    output logic                   e_cch_rhit,
    output logic                   e_cch_whit
);

    localparam int IDX_W  = $clog2(NUM_ROWS);
    localparam int TAG_W  = ADDR_W - IDX_W - $clog2(DATA_W / 8);
    localparam int TROW_W = 2 * (TAG_W + 1) + 1;  // Two ways plus LRU bit
    localparam int DROW_W = 2 * DATA_W;

    logic              tag_we;
    logic [IDX_W-1:0]  tag_waddr;
    logic [TROW_W-1:0] tag_wdata;
    logic              tag_re;
    logic [IDX_W-1:0]  tag_raddr;
    logic [TROW_W-1:0] tag_rdata;

    logic              dat_we;
    logic [IDX_W-1:0]  dat_waddr;
    logic [DROW_W-1:0] dat_wdata;
    logic              dat_re;
    logic [IDX_W-1:0]  dat_raddr;
    logic [DROW_W-1:0] dat_rdata;

    l2_cache_ctrl #(
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W),
        .NUM_ROWS  (NUM_ROWS),
        .MEM_DELAY (MEM_DELAY),
        .ID_W      (ID_W)
    ) ctrl (.*);

    mem_beh_1r1w #(.WORDS(NUM_ROWS), .DW(TROW_W), .LATENCY(MEM_DELAY)) tag_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .write (tag_we),
        .waddr (tag_waddr),
        .din   (tag_wdata),
        .read  (tag_re),
        .raddr (tag_raddr),
        .dout  (tag_rdata)
    );

    mem_beh_1r1w #(.WORDS(NUM_ROWS), .DW(DROW_W), .LATENCY(MEM_DELAY)) dat_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .write (dat_we),
        .waddr (dat_waddr),
        .din   (dat_wdata),
        .read  (dat_re),
        .raddr (dat_raddr),
        .dout  (dat_rdata)
    );

endmodule

// ==== verilog/mem_beh_1r1w.sv ====
module mem_beh_1r1w #(
    parameter int  WORDS   = 64,
    parameter int  DW      = 32,
    parameter int  LATENCY = 3,
    localparam int AW      = $clog2(WORDS)
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          write,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] din,
    input  logic          read,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] dout
);

    logic [DW-1:0] mem [WORDS];
    logic [DW-1:0] pipe [LATENCY];

    // Contents start at zero so every line reads back invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[waddr] <= din;
        end
    end

    // Read pipeline that takes a new read every cycle
    always_ff @(posedge clk) begin
        if (read) begin
            pipe[0] <= mem[raddr];  // Sees a write from the previous cycle
        end
        for (int i = 1; i < LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign dout = pipe[LATENCY-1];

endmodule
